//--- include/ysyx_core_cfg.svh
`ifndef YSYX_CORE_CFG_SVH
`define YSYX_CORE_CFG_SVH

// core build parameters
// shared by the packages and the rtl blocks

// datapath width
// rv32i so every data word is 32 bits
`define XLEN 32

// number of general purpose registers
// x0 included, it always reads as zero
`define NUM_REGS 32

// pc value taken on reset
// matches the usual simulator load address
`define RESET_PC 32'h8000_0000

// fixed step of the pc per instruction
`define PC_STEP 32'd4

`endif

//--- hdl/rv_isa_pkg.sv
`include "ysyx_core_cfg.svh"

package rv_isa_pkg;

    // data and instruction word
    typedef logic [`XLEN-1:0] word_t;
    // register index into the gpr file
    typedef logic [4:0] reg_addr_t;

    // instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes handled by this core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // funct3 for OP and OP-IMM
    // add/sub share one code, funct7 picks
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    // srl and sra also split on funct7
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 values
    // alt selects sub and sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

//--- hdl/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // alu operation code
    // pass2 forwards operand 2 unchanged
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASS2 = 4'd10
    } alu_op_e;

    // operand 1 source
    typedef logic [1:0] src1_sel_t;
    localparam src1_sel_t SRC1_RS1  = 2'd0;
    localparam src1_sel_t SRC1_PC   = 2'd1;
    localparam src1_sel_t SRC1_ZERO = 2'd2;

    // operand 2 source
    typedef logic [1:0] src2_sel_t;
    localparam src2_sel_t SRC2_RS2  = 2'd0;
    localparam src2_sel_t SRC2_IMM  = 2'd1;
    localparam src2_sel_t SRC2_FOUR = 2'd2;
    localparam src2_sel_t SRC2_ZERO = 2'd3;

endpackage

//--- hdl/ysyx_imm_gen.sv
`timescale 1ns/1ps

module ysyx_imm_gen (
    input  rv_isa_pkg::word_t inst_i,
    output rv_isa_pkg::word_t imm_o
);
    import rv_isa_pkg::*;

    opcode_t opcode;
    // candidate immediates
    word_t   imm_i_type;
    word_t   imm_u_type;
    logic    is_u_type;

    assign opcode = inst_i[6:0];

    // 12 bit immediate in [31:20], sign from bit 31
    // shift forms reuse it, shamt is the low 5 bits
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};

    // upper 20 bits, low 12 cleared
    assign imm_u_type = {inst_i[31:12], 12'b0};

    // only lui and auipc carry a u immediate
    assign is_u_type = (opcode == OPC_LUI) || (opcode == OPC_AUIPC);

    // everything else here is i type
    // r type ignores the value anyway
    assign imm_o = is_u_type ? imm_u_type : imm_i_type;

endmodule

//--- hdl/ysyx_decoder.sv
`timescale 1ns/1ps

module ysyx_decoder (
    input  rv_isa_pkg::word_t        inst_i,
    output core_ctrl_pkg::alu_op_e   aluop_o,
    output core_ctrl_pkg::src1_sel_t src1_sel_o,
    output core_ctrl_pkg::src2_sel_t src2_sel_o,
    output logic                     wd_o,
    output rv_isa_pkg::reg_addr_t    wreg_o,
    output rv_isa_pkg::reg_addr_t    rs1_addr_o,
    output rv_isa_pkg::reg_addr_t    rs2_addr_o,
    output rv_isa_pkg::word_t        imm_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    // raw decode before the legality override
    alu_op_e op;
    logic    legal;

    // fixed field positions
    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign wreg_o     = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    always_comb begin
        op         = ALU_ADD;
        legal      = 1'b0;
        src1_sel_o = SRC1_RS1;
        src2_sel_o = SRC2_RS2;
        case (opcode)
            // register register ops
            OPC_OP: begin
                src2_sel_o = SRC2_RS2;
                case (funct3)
                    F3_ADD_SUB: op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     op = ALU_SLL;
                    F3_SLT:     op = ALU_SLT;
                    F3_SLTU:    op = ALU_SLTU;
                    F3_XOR:     op = ALU_XOR;
                    F3_SRL_SRA: op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      op = ALU_OR;
                    default:    op = ALU_AND;
                endcase
                // alt only valid for sub and sra
                if (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA) begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end else begin
                    legal = (funct7 == F7_BASE);
                end
            end
            // register immediate ops
            OPC_OP_IMM: begin
                src2_sel_o = SRC2_IMM;
                legal      = 1'b1;
                case (funct3)
                    F3_ADD_SUB: op = ALU_ADD;
                    F3_SLT:     op = ALU_SLT;
                    F3_SLTU:    op = ALU_SLTU;
                    F3_XOR:     op = ALU_XOR;
                    F3_OR:      op = ALU_OR;
                    F3_AND:     op = ALU_AND;
                    F3_SLL: begin
                        op    = ALU_SLL;
                        legal = (funct7 == F7_BASE);
                    end
                    default: begin
                        // srli / srai, shamt sits below funct7
                        op    = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                endcase
            end
            // lui is zero plus upper immediate
            OPC_LUI: begin
                src1_sel_o = SRC1_ZERO;
                src2_sel_o = SRC2_IMM;
                legal      = 1'b1;
            end
            // auipc adds the upper immediate to pc
            OPC_AUIPC: begin
                src1_sel_o = SRC1_PC;
                src2_sel_o = SRC2_IMM;
                legal      = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // illegal encodings fall back to add
    assign aluop_o = legal ? op : ALU_ADD;
    // x0 filtered here, regfile trusts the enable
    assign wd_o    = legal && (wreg_o != '0);

    ysyx_imm_gen u_imm_gen (
        .inst_i (inst_i),
        .imm_o  (imm_o)
    );

endmodule

//--- hdl/ysyx_arch_state.sv
`timescale 1ns/1ps
`include "ysyx_core_cfg.svh"

module ysyx_arch_state (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t rs2_addr_i,
    input  rv_isa_pkg::reg_addr_t wr_addr_i,
    input  logic                  wr_en_i,
    input  rv_isa_pkg::word_t     wr_data_i,
    input  logic                  advance_i,
    output rv_isa_pkg::word_t     rs1_data_o,
    output rv_isa_pkg::word_t     rs2_data_o,
    output rv_isa_pkg::word_t     pc_o
);
    import rv_isa_pkg::*;

    // general registers
    word_t regs [`NUM_REGS];
    word_t pc_q;

    // gpr write port
    // x0 stays zero since wr_en_i never hits address 0
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // combinational read ports
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    // pc steps once per accepted instruction
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (advance_i) begin
            pc_q <= pc_q + `PC_STEP;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- hdl/ysyx_exec.sv
`timescale 1ns/1ps

module ysyx_exec (
    input  core_ctrl_pkg::alu_op_e   aluop_i,
    input  core_ctrl_pkg::src1_sel_t src1_sel_i,
    input  core_ctrl_pkg::src2_sel_t src2_sel_i,
    input  rv_isa_pkg::word_t        rs1_data_i,
    input  rv_isa_pkg::word_t        rs2_data_i,
    input  rv_isa_pkg::word_t        pc_i,
    input  rv_isa_pkg::word_t        imm_i,
    output rv_isa_pkg::word_t        result_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t      op1;
    word_t      op2;
    // shift amount from operand 2
    logic [4:0] shamt;

    // operand 1 mux, unused code reads as zero
    always_comb begin
        case (src1_sel_i)
            SRC1_RS1: op1 = rs1_data_i;
            SRC1_PC:  op1 = pc_i;
            default:  op1 = '0;
        endcase
    end

    // operand 2 mux
    always_comb begin
        case (src2_sel_i)
            SRC2_RS2:  op2 = rs2_data_i;
            SRC2_IMM:  op2 = imm_i;
            SRC2_FOUR: op2 = 32'd4;
            default:   op2 = '0;
        endcase
    end

    assign shamt = op2[4:0];

    always_comb begin
        result_o = '0;
        case (aluop_i)
            ALU_ADD:   result_o = op1 + op2;
            ALU_SUB:   result_o = op1 - op2;
            ALU_SLL:   result_o = op1 << shamt;
            // compares give 0 or 1 in bit 0
            ALU_SLT:   result_o[0] = $signed(op1) < $signed(op2);
            ALU_SLTU:  result_o[0] = op1 < op2;
            ALU_XOR:   result_o = op1 ^ op2;
            ALU_SRL:   result_o = op1 >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:   result_o = word_t'($signed(op1) >>> shamt);
            ALU_OR:    result_o = op1 | op2;
            ALU_AND:   result_o = op1 & op2;
            ALU_PASS2: result_o = op2;
            default:   result_o = '0;
        endcase
    end

endmodule

//--- hdl/ysyx_core_top.sv
`timescale 1ns/1ps

module ysyx_core_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  inst_valid_i,
    input  rv_isa_pkg::word_t     inst_i,
    output rv_isa_pkg::word_t     pc_o,
    output logic                  wb_en_o,
    output rv_isa_pkg::reg_addr_t wb_addr_o,
    output rv_isa_pkg::word_t     wb_data_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    // decoder to arch state and exec
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    alu_op_e   aluop;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    logic      wd;
    word_t     imm;
    // register read data
    word_t     rs1_data;
    word_t     rs2_data;

    // write only for a valid instruction
    assign wb_en_o = inst_valid_i & wd;

    ysyx_decoder u_decoder (
        .inst_i     (inst_i),
        .aluop_o    (aluop),
        .src1_sel_o (src1_sel),
        .src2_sel_o (src2_sel),
        .wd_o       (wd),
        .wreg_o     (wb_addr_o),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .imm_o      (imm)
    );

    // pc steps on every valid strobe, even if nothing is written
    ysyx_arch_state u_arch_state (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wr_addr_i  (wb_addr_o),
        .wr_en_i    (wb_en_o),
        .wr_data_i  (wb_data_o),
        .advance_i  (inst_valid_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .pc_o       (pc_o)
    );

    ysyx_exec u_exec (
        .aluop_i    (aluop),
        .src1_sel_i (src1_sel),
        .src2_sel_i (src2_sel),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc_o),
        .imm_i      (imm),
        .result_o   (wb_data_o)
    );

endmodule

//--- testbench/ysyx_core_properties.sv
`timescale 1ns/1ps
`include "ysyx_core_cfg.svh"

module ysyx_core_properties (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  inst_valid_i,
    input logic                  wb_en_o,
    input rv_isa_pkg::reg_addr_t wb_addr_o,
    input rv_isa_pkg::word_t     pc_o
);

    // writeback only for a valid strobe
    wb_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_en_o |-> inst_valid_i)
        else $error("write enable high without a valid instruction");

    // x0 is filtered in the decoder
    wb_not_x0: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_en_o |-> (wb_addr_o != 5'd0))
        else $error("write enable high for register x0");

    // one step per accepted instruction
    pc_steps: assert property (@(posedge clk_i) disable iff (reset_i)
        inst_valid_i |=> (pc_o == $past(pc_o) + `PC_STEP))
        else $error("pc did not advance after a valid instruction");

    pc_holds: assert property (@(posedge clk_i) disable iff (reset_i)
        !inst_valid_i |=> $stable(pc_o))
        else $error("pc changed in an idle cycle");

endmodule

bind ysyx_core_top ysyx_core_properties u_properties (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .inst_valid_i (inst_valid_i),
    .wb_en_o      (wb_en_o),
    .wb_addr_o    (wb_addr_o),
    .pc_o         (pc_o)
);

//--- testbench/ysyx_core_tb.sv
`timescale 1ns/1ps
`include "ysyx_core_cfg.svh"

module ysyx_core_tb;
    import rv_isa_pkg::*;

    // sw opcode, not supported by this core
    localparam opcode_t OPC_STORE = 7'b0100011;

    logic      clk_i;
    logic      reset_i;
    logic      inst_valid_i;
    word_t     inst_i;
    word_t     pc_o;
    logic      wb_en_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;

    // reference architectural state
    word_t model_regs [`NUM_REGS];
    word_t model_pc;

    ysyx_core_top u_dut (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_o         (pc_o),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    task automatic abort_run;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    // instruction encoders
    function automatic word_t encode_r(funct7_t f7, funct3_t f3, reg_addr_t rd,
                                       reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t encode_i(funct3_t f3, reg_addr_t rd, reg_addr_t rs1,
                                       logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // shamt sits where imm[4:0] would be
    function automatic word_t encode_shift(funct7_t f7, funct3_t f3, reg_addr_t rd,
                                           reg_addr_t rs1, logic [4:0] shamt);
        return {f7, shamt, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t encode_u(opcode_t opc, reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    // rv32i arithmetic by funct3, alt picks sub or sra
    function automatic word_t alu_reference(funct3_t f3, logic alt, word_t a, word_t b);
        logic [4:0] sh;
        begin
            sh = b[4:0];
            case (f3)
                F3_ADD_SUB: alu_reference = alt ? a - b : a + b;
                F3_SLL:     alu_reference = a << sh;
                // differing signs decide the signed compare alone
                F3_SLT:     alu_reference = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
                F3_SLTU:    alu_reference = {31'd0, a < b};
                F3_XOR:     alu_reference = a ^ b;
                // sign fill built by hand for sra
                F3_SRL_SRA: alu_reference = alt ?
                    ((a >> sh) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> sh))) : a >> sh;
                F3_OR:      alu_reference = a | b;
                default:    alu_reference = a & b;
            endcase
        end
    endfunction

    // expected writeback from the model state before the edge
    task automatic predict(input word_t inst, output logic en, output word_t data);
        opcode_t opc;
        funct3_t f3;
        funct7_t f7;
        word_t   a;
        word_t   b;
        logic    legal;
        begin
            opc   = inst[6:0];
            f3    = inst[14:12];
            f7    = inst[31:25];
            a     = model_regs[inst[19:15]];
            b     = model_regs[inst[24:20]];
            legal = 1'b0;
            data  = '0;
            case (opc)
                OPC_OP: begin
                    legal = (f7 == F7_BASE) ||
                            (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
                    data  = alu_reference(f3, f7 == F7_ALT, a, b);
                end
                OPC_OP_IMM: begin
                    b = {{20{inst[31]}}, inst[31:20]};
                    if (f3 == F3_SLL) begin
                        legal = (f7 == F7_BASE);
                    end else if (f3 == F3_SRL_SRA) begin
                        legal = (f7 == F7_BASE) || (f7 == F7_ALT);
                    end else begin
                        legal = 1'b1;
                    end
                    // no subtract among the immediates
                    data = alu_reference(f3, f3 == F3_SRL_SRA && f7 == F7_ALT, a, b);
                end
                OPC_LUI: begin
                    legal = 1'b1;
                    data  = {inst[31:12], 12'h000};
                end
                OPC_AUIPC: begin
                    legal = 1'b1;
                    data  = model_pc + {inst[31:12], 12'h000};
                end
                default: legal = 1'b0;
            endcase
            en = legal && (inst[11:7] != 5'd0);
        end
    endtask

    task automatic check_writeback(input word_t inst, input logic exp_en, input word_t exp_data);
        assert (wb_en_o === exp_en) else begin
            $display("Error: wb_en_o expected %h got %h, inst %h", exp_en, wb_en_o, inst);
            abort_run();
        end
        assert (wb_addr_o === inst[11:7]) else begin
            $display("Error: wb_addr_o expected %h got %h, inst %h", inst[11:7], wb_addr_o, inst);
            abort_run();
        end
        if (exp_en) begin
            assert (wb_data_o === exp_data) else begin
                $display("Error: wb_data_o expected %h got %h, inst %h",
                         exp_data, wb_data_o, inst);
                abort_run();
            end
        end
    endtask

    // pc must match right after the next rising edge
    task automatic await_pc(input word_t exp_pc);
        @(negedge clk_i);
        assert (pc_o === exp_pc) else begin
            $display("Error: pc_o expected %h got %h", exp_pc, pc_o);
            abort_run();
        end
    endtask

    // one valid instruction, checked before the rising edge
    task automatic issue(input word_t inst);
        logic  exp_en;
        word_t exp_data;
        begin
            inst_i       = inst;
            inst_valid_i = 1'b1;
            #1;
            predict(inst, exp_en, exp_data);
            check_writeback(inst, exp_en, exp_data);
            if (exp_en) begin
                model_regs[inst[11:7]] = exp_data;
            end
            model_pc = model_pc + 32'd4;
            await_pc(model_pc);
        end
    endtask

    // gap cycle, a legal word sits on the bus but valid is low
    task automatic idle_cycle;
        inst_valid_i = 1'b0;
        inst_i       = encode_i(F3_ADD_SUB, 5'd1, 5'd1, 12'h001);
        #1;
        assert (wb_en_o === 1'b0) else begin
            $display("Error: wb_en_o expected %h got %h with valid low", 1'b0, wb_en_o);
            abort_run();
        end
        await_pc(model_pc);
    endtask

    task automatic test_reset_idle;
        assert (pc_o === `RESET_PC) else begin
            $display("Error: pc_o expected %h got %h after reset", `RESET_PC, pc_o);
            abort_run();
        end
        repeat (3) idle_cycle();
    endtask

    // all r ops on one register pair, results into x10..x19
    task automatic run_r_ops(input reg_addr_t rs1, input reg_addr_t rs2);
        for (int f = 0; f < 8; f++) begin
            issue(encode_r(F7_BASE, funct3_t'(f), reg_addr_t'(10 + f), rs1, rs2));
        end
        issue(encode_r(F7_ALT, F3_ADD_SUB, 5'd18, rs1, rs2));
        issue(encode_r(F7_ALT, F3_SRL_SRA, 5'd19, rs1, rs2));
    endtask

    task automatic test_r_type;
        // x1 = -7, x2 = 3, x3 = 0x80000000, x4 = 0x800007ff
        issue(encode_i(F3_ADD_SUB, 5'd1, 5'd0, 12'hFF9));
        issue(encode_i(F3_ADD_SUB, 5'd2, 5'd0, 12'h003));
        issue(encode_u(OPC_LUI, 5'd3, 20'h80000));
        issue(encode_i(F3_ADD_SUB, 5'd4, 5'd3, 12'h7FF));
        run_r_ops(5'd1, 5'd2);
        run_r_ops(5'd2, 5'd1);
        // shift by 31 from the low bits of x4
        run_r_ops(5'd3, 5'd4);
        run_r_ops(5'd1, 5'd3);
    endtask

    task automatic test_op_imm;
        logic [11:0] imms [4];
        logic [4:0]  shamts [3];
        begin
            imms   = '{12'h7FF, 12'h800, 12'hFFF, 12'h001};
            shamts = '{5'd0, 5'd31, 5'd7};
            for (int i = 0; i < 4; i++) begin
                for (int f = 0; f < 8; f++) begin
                    if (f != 1 && f != 5) begin
                        issue(encode_i(funct3_t'(f), reg_addr_t'(20 + f),
                                       (i % 2 == 0) ? 5'd1 : 5'd3, imms[i]));
                    end
                end
            end
            for (int s = 0; s < 3; s++) begin
                for (int r = 0; r < 2; r++) begin
                    issue(encode_shift(F7_BASE, F3_SLL, 5'd28, r ? 5'd3 : 5'd1, shamts[s]));
                    issue(encode_shift(F7_BASE, F3_SRL_SRA, 5'd29, r ? 5'd3 : 5'd1, shamts[s]));
                    issue(encode_shift(F7_ALT, F3_SRL_SRA, 5'd30, r ? 5'd3 : 5'd1, shamts[s]));
                end
            end
        end
    endtask

    task automatic test_upper;
        issue(encode_u(OPC_LUI, 5'd8, 20'hABCDE));
        issue(encode_u(OPC_AUIPC, 5'd9, 20'h12345));
        // negative offset wraps below the pc
        issue(encode_u(OPC_AUIPC, 5'd9, 20'hFFFFF));
        issue(encode_r(F7_BASE, F3_ADD_SUB, 5'd10, 5'd8, 5'd9));
    endtask

    task automatic test_x0_and_illegal;
        issue(encode_i(F3_ADD_SUB, 5'd0, 5'd2, 12'h055));
        issue(encode_u(OPC_LUI, 5'd0, 20'h12345));
        // sw x2, 12(x1), rd field holds imm[4:0]
        issue({7'b0000000, 5'd2, 5'd1, 3'b010, 5'd12, OPC_STORE});
        // funct7 of mul is not part of rv32i
        issue(encode_r(7'b0000001, F3_ADD_SUB, 5'd13, 5'd1, 5'd2));
        // x0 must still read as zero
        issue(encode_r(F7_BASE, F3_ADD_SUB, 5'd14, 5'd0, 5'd2));
        issue(encode_r(F7_BASE, F3_OR, 5'd15, 5'd0, 5'd0));
    endtask

    task automatic test_random;
        word_t     rnd;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        funct3_t   f3;
        funct7_t   f7;
        begin
            for (int n = 0; n < 200; n++) begin
                rnd = $urandom;
                if (rnd[1:0] == 2'b00) begin
                    idle_cycle();
                end
                rnd = $urandom;
                rd  = rnd[4:0];
                rs1 = rnd[9:5];
                rs2 = rnd[14:10];
                f3  = rnd[17:15];
                f7  = (rnd[20] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? F7_ALT : F7_BASE;
                case (rnd[19:18])
                    2'd0: issue(encode_r(f7, f3, rd, rs1, rs2));
                    2'd1: begin
                        if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                            issue(encode_shift(f7, f3, rd, rs1, rnd[25:21]));
                        end else begin
                            issue(encode_i(f3, rd, rs1, rnd[31:20]));
                        end
                    end
                    2'd2: issue(encode_u(OPC_LUI, rd, rnd[31:12]));
                    default: issue(encode_u(OPC_AUIPC, rd, rnd[31:12]));
                endcase
            end
        end
    endtask

    initial begin
        clk_i        = 1'b0;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        void'($urandom(54100));
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        model_pc = `RESET_PC;
        // reset spans ten rising edges
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_i);
        end
        reset_i = 1'b0;
        test_reset_idle();
        test_r_type();
        test_op_imm();
        test_upper();
        test_x0_and_illegal();
        test_random();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/ysyx_imm_gen.sv
hdl/ysyx_decoder.sv
hdl/ysyx_arch_state.sv
hdl/ysyx_exec.sv
hdl/ysyx_core_top.sv
testbench/ysyx_core_properties.sv
testbench/ysyx_core_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := ysyx_core_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a missing pass line counts as failure
run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
